//--- hw/sapPkg.sv
package sapPkg;

    ////////////////////
    // data word
    ////////////////////

    typedef logic [15:0] word_t;    // data, address and instruction

    // read source codes, unlisted codes read as zero
    typedef enum logic [3:0] {
        srcNone = 4'd0,
        srcIn   = 4'd4,
        srcPc   = 4'd6,
        srcR0   = 4'd7,
        srcR1   = 4'd8,
        srcR2   = 4'd9,
        srcR3   = 4'd10,
        srcAcc  = 4'd11,
        srcBReg = 4'd12,
        srcC    = 4'd13,
        srcOut  = 4'd14
    } srcSel_t;

    typedef enum logic [3:0] {
        dstR0   = 4'd3,
        dstR1   = 4'd4,
        dstR2   = 4'd5,
        dstR3   = 4'd6,
        dstAcc  = 4'd7,
        dstBReg = 4'd8,
        dstC    = 4'd9,
        dstOut  = 4'd10    // anything else is no write
    } dstSel_t;

    typedef enum logic [3:0] {
        opAnd = 4'd0,
        opOr  = 4'd1,
        opNot = 4'd10,
        opXor = 4'd11,
        opAdd = 4'd12,
        opSub = 4'd13
    } aluOp_t;

    // unsigned compares of a against b
    typedef enum logic [3:0] {
        brEq = 4'd4,
        brNe = 4'd5,
        brGt = 4'd6,
        brGe = 4'd7,
        brLt = 4'd8,
        brLe = 4'd9
    } brCond_t;

    typedef enum logic [1:0] {
        wrMove,
        wrAlu,
        wrImm
    } wrSrc_t;

    ////////////////////
    // control and bus
    ////////////////////

    typedef struct packed {
        srcSel_t    srcA;
        srcSel_t    srcB;
        srcSel_t    srcC;       // branch target
        logic [3:0] op;         // raw f4 nibble
        logic       wrEn;
        dstSel_t    dst;
        wrSrc_t     wrSrc;
        logic       latchIn;    // input latch strobe
    } ctrl_t;

    typedef struct packed {
        logic  req;
        word_t addr;
    } memReq_t;

    typedef struct packed {
        logic  ack;
        word_t data;
    } memRsp_t;

    typedef enum logic [1:0] {
        stFetch,
        stDecode,
        stExec,
        stOperand
    } seqState_t;

endpackage

//--- hw/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic [3:0]    op,
    input  sapPkg::word_t a,
    input  sapPkg::word_t b,
    output sapPkg::word_t result,
    output logic          cmpTrue
);

    ////////////////////
    // arithmetic, logic
    ////////////////////

    always_comb begin
        case (sapPkg::aluOp_t'(op))
            sapPkg::opAnd: result = a & b;
            sapPkg::opOr:  result = a | b;
            sapPkg::opNot: result = ~a;        // b ignored
            sapPkg::opXor: result = a ^ b;
            sapPkg::opAdd: result = a + b;     // wraps at 16 bits
            sapPkg::opSub: result = a - b;
            default:       result = '0;
        endcase
    end

    ////////////////////
    // branch compare
    ////////////////////

    // all unsigned
    always_comb begin
        case (sapPkg::brCond_t'(op))
            sapPkg::brEq: cmpTrue = (a == b);
            sapPkg::brNe: cmpTrue = (a != b);
            sapPkg::brGt: cmpTrue = (a > b);
            sapPkg::brGe: cmpTrue = (a >= b);
            sapPkg::brLt: cmpTrue = (a < b);
            sapPkg::brLe: cmpTrue = (a <= b);
            default:      cmpTrue = 1'b0;
        endcase
    end

endmodule

//--- hw/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
    parameter sapPkg::word_t resetAddr = 16'h0000
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            fetchStart,
    input  logic            pcLoad,
    input  sapPkg::word_t   pcTarget,
    output sapPkg::memReq_t memReq,
    input  sapPkg::memRsp_t memRsp,
    output logic            fetchDone,
    output sapPkg::word_t   fetchWord,
    output sapPkg::word_t   pc
);

    // four-phase handshake progress
    typedef enum logic [1:0] {
        phIdle,
        phWaitAck,
        phWaitDrop
    } phase_t;

    phase_t        phase;
    logic          reqQ;
    sapPkg::word_t addrQ;

    assign memReq = '{req: reqQ, addr: addrQ};

    ////////////////////
    // control and pc
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= phIdle;
            reqQ      <= 1'b0;
            fetchDone <= 1'b0;
            pc        <= resetAddr;
        end else begin
            fetchDone <= 1'b0;
            if (pcLoad) begin
                pc <= pcTarget;     // jump or taken branch
            end
            case (phase)
                phIdle: begin
                    if (fetchStart) begin
                        reqQ  <= 1'b1;
                        phase <= phWaitAck;
                    end
                end
                phWaitAck: begin
                    if (memRsp.ack) begin
                        reqQ  <= 1'b0;     // word captured below
                        phase <= phWaitDrop;
                    end
                end
                phWaitDrop: begin
                    // cycle closes once ack is gone
                    if (!memRsp.ack) begin
                        pc        <= pc + 16'd1;
                        fetchDone <= 1'b1;
                        phase     <= phIdle;
                    end
                end
                default: phase <= phIdle;
            endcase
        end
    end

    // address and fetched word
    always_ff @(posedge clk) begin
        if (phase == phIdle && fetchStart) begin
            addrQ <= pc;
        end
        if (phase == phWaitAck && memRsp.ack) begin
            fetchWord <= memRsp.data;
        end
    end

    // ack only answers a pending request
    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(memRsp.ack) |-> reqQ);

    // memory must have dropped ack before a new request
    reqAfterAckLow: assert property (@(posedge clk) disable iff (rst)
        $rose(reqQ) |-> !memRsp.ack);

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic          clk,
    input  logic          rst,
    input  sapPkg::word_t inPort,
    input  sapPkg::word_t pc,
    input  sapPkg::ctrl_t ctrl,
    input  sapPkg::word_t aluResult,
    input  sapPkg::word_t immWord,
    output sapPkg::word_t rdA,
    output sapPkg::word_t rdB,
    output sapPkg::word_t rdC,
    output sapPkg::word_t outPort,
    output logic          outStrobe
);

    sapPkg::word_t r [0:3];     // r0 to r3
    sapPkg::word_t acc;
    sapPkg::word_t bReg;
    sapPkg::word_t c;
    sapPkg::word_t inLatch;
    sapPkg::word_t wrData;

    ////////////////////
    // read side
    ////////////////////

    function automatic sapPkg::word_t readSrc(input sapPkg::srcSel_t sel);
        case (sel)
            sapPkg::srcIn:   readSrc = inLatch;
            sapPkg::srcPc:   readSrc = pc;      // already incremented
            sapPkg::srcR0:   readSrc = r[0];
            sapPkg::srcR1:   readSrc = r[1];
            sapPkg::srcR2:   readSrc = r[2];
            sapPkg::srcR3:   readSrc = r[3];
            sapPkg::srcAcc:  readSrc = acc;
            sapPkg::srcBReg: readSrc = bReg;
            sapPkg::srcC:    readSrc = c;
            sapPkg::srcOut:  readSrc = outPort;
            default:         readSrc = '0;      // dropped sources
        endcase
    endfunction

    always_comb begin
        rdA = readSrc(ctrl.srcA);
        rdB = readSrc(ctrl.srcB);
        rdC = readSrc(ctrl.srcC);
    end

    always_comb begin
        case (ctrl.wrSrc)
            sapPkg::wrAlu: wrData = aluResult;
            sapPkg::wrImm: wrData = immWord;
            default:       wrData = rdA;   // plain move
        endcase
    end

    ////////////////////
    // write side
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                r[i] <= '0;
            end
            acc       <= '0;
            bReg      <= '0;
            c         <= '0;
            inLatch   <= '0;
            outPort   <= '0;
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= ctrl.wrEn && (ctrl.dst == sapPkg::dstOut);
            if (ctrl.latchIn) inLatch <= inPort;
            if (ctrl.wrEn) begin
                case (ctrl.dst)
                    sapPkg::dstR0:   r[0]    <= wrData;
                    sapPkg::dstR1:   r[1]    <= wrData;
                    sapPkg::dstR2:   r[2]    <= wrData;
                    sapPkg::dstR3:   r[3]    <= wrData;
                    sapPkg::dstAcc:  acc     <= wrData;
                    sapPkg::dstBReg: bReg    <= wrData;
                    sapPkg::dstC:    c       <= wrData;
                    sapPkg::dstOut:  outPort <= wrData;
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- hw/seqControl.sv
`timescale 1ns/1ps

module seqControl (
    input  logic          clk,
    input  logic          rst,
    input  logic          fetchDone,
    input  sapPkg::word_t fetchWord,
    input  logic          cmpTrue,
    input  sapPkg::word_t rdC,
    output logic          fetchStart,
    output sapPkg::ctrl_t ctrl,
    output logic          pcLoad,
    output sapPkg::word_t pcTarget
);

    sapPkg::seqState_t state;
    sapPkg::word_t     ir;
    logic              waiting;    // fetch in progress
    logic [3:0]        f1, f2, f3, f4;
    logic              isJump, isLoadImm, isMove, isBranch, isAlu;

    assign f1 = ir[15:12];
    assign f2 = ir[11:8];
    assign f3 = ir[7:4];
    assign f4 = ir[3:0];

    ////////////////////
    // decode
    ////////////////////

    always_comb begin
        isJump    = 1'b0;
        isLoadImm = 1'b0;
        isMove    = 1'b0;
        isBranch  = 1'b0;
        isAlu     = 1'b0;
        if (ir == '0) begin
            // nop sets nothing
        end else if (f1 == 4'd0 && f2 == 4'd0 && f3 == 4'd0 && f4 == 4'd1) begin
            isJump = 1'b1;
        end else if (f1 == 4'd1 && f3 == 4'd0 && f4 == 4'd2) begin
            isLoadImm = 1'b1;
        end else if (f3 == 4'd0 && f4 == 4'd0) begin
            isMove = 1'b1;
        end else if (f4 >= sapPkg::brEq && f4 <= sapPkg::brLe) begin
            isBranch = 1'b1;
        end else if (f4 inside {sapPkg::opAnd, sapPkg::opOr, sapPkg::opNot,
                                sapPkg::opXor, sapPkg::opAdd, sapPkg::opSub}) begin
            isAlu = 1'b1;
        end
        // mul, div and the rest fall through as nop
    end

    always_comb begin
        ctrl         = '0;
        ctrl.srcA    = sapPkg::srcSel_t'(isAlu ? f2 : f1);
        ctrl.srcB    = sapPkg::srcSel_t'(isAlu ? f3 : f2);
        ctrl.srcC    = sapPkg::srcSel_t'(f3);
        ctrl.op      = f4;
        ctrl.dst     = sapPkg::dstSel_t'(isAlu ? f1 : f2);
        ctrl.latchIn = (state == sapPkg::stDecode);
        if (state == sapPkg::stExec && (isMove || isAlu)) begin
            ctrl.wrEn  = 1'b1;
            ctrl.wrSrc = isAlu ? sapPkg::wrAlu : sapPkg::wrMove;
        end else if (state == sapPkg::stOperand && fetchDone && isLoadImm) begin
            ctrl.wrEn  = 1'b1;     // immediate lands with the operand
            ctrl.wrSrc = sapPkg::wrImm;
        end
    end

    assign pcLoad   = (state == sapPkg::stExec) && (isJump || (isBranch && cmpTrue));
    assign pcTarget = isJump ? fetchWord : rdC;

    ////////////////////
    // sequencing
    ////////////////////

    assign fetchStart = (state == sapPkg::stFetch || state == sapPkg::stOperand) && !waiting;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= sapPkg::stFetch;
            waiting <= 1'b0;
            ir      <= '0;
        end else begin
            if (fetchStart) begin
                waiting <= 1'b1;
            end else if (fetchDone) begin
                waiting <= 1'b0;
            end
            case (state)
                sapPkg::stFetch: begin
                    if (fetchDone) begin
                        ir    <= fetchWord;
                        state <= sapPkg::stDecode;
                    end
                end
                sapPkg::stDecode: begin
                    state <= (isJump || isLoadImm) ? sapPkg::stOperand : sapPkg::stExec;
                end
                sapPkg::stOperand: begin
                    if (fetchDone) state <= sapPkg::stExec;
                end
                default: state <= sapPkg::stFetch;   // after exec
            endcase
        end
    end

    // fetchDone only answers a fetch this sequencer started
    doneWhileFetching: assert property (@(posedge clk) disable iff (rst)
        fetchDone |-> waiting && (state == sapPkg::stFetch || state == sapPkg::stOperand));

endmodule

//--- hw/sapCore.sv
`timescale 1ns/1ps

module sapCore #(
    parameter sapPkg::word_t resetAddr = 16'h0000   // program start
) (
    input  logic            clk,
    input  logic            rst,
    input  sapPkg::word_t   inPort,
    output sapPkg::word_t   outPort,
    output logic            outStrobe,
    output sapPkg::memReq_t memReq,
    input  sapPkg::memRsp_t memRsp
);

    logic          fetchStart;
    logic          fetchDone;
    sapPkg::word_t fetchWord;
    sapPkg::word_t pc;
    logic          pcLoad;
    sapPkg::word_t pcTarget;
    sapPkg::ctrl_t ctrl;
    sapPkg::word_t rdA, rdB, rdC;
    sapPkg::word_t aluResult;
    logic          cmpTrue;

    fetchUnit #(
        .resetAddr(resetAddr)
    ) i_fetchUnit (
        .clk(clk), .rst(rst),
        .fetchStart(fetchStart), .pcLoad(pcLoad), .pcTarget(pcTarget),
        .memReq(memReq), .memRsp(memRsp),
        .fetchDone(fetchDone), .fetchWord(fetchWord), .pc(pc)
    );

    seqControl i_seqControl (
        .clk(clk), .rst(rst),
        .fetchDone(fetchDone), .fetchWord(fetchWord), .cmpTrue(cmpTrue), .rdC(rdC),
        .fetchStart(fetchStart), .ctrl(ctrl), .pcLoad(pcLoad), .pcTarget(pcTarget)
    );

    // operand word doubles as the immediate
    regFile i_regFile (
        .clk(clk), .rst(rst),
        .inPort(inPort), .pc(pc), .ctrl(ctrl),
        .aluResult(aluResult), .immWord(fetchWord),
        .rdA(rdA), .rdB(rdB), .rdC(rdC),
        .outPort(outPort), .outStrobe(outStrobe)
    );

    aluUnit i_aluUnit (
        .op(ctrl.op), .a(rdA), .b(rdB),
        .result(aluResult), .cmpTrue(cmpTrue)
    );

endmodule

//--- test/progMemModel.sv
`timescale 1ns/1ps

module progMemModel (
    input  logic            clk,
    input  logic            rst,
    input  sapPkg::memReq_t memReq,
    output sapPkg::memRsp_t memRsp
);

    sapPkg::word_t mem [0:63];     // program words, filled by the testbench
    integer        seed = 8015;
    integer        delay;
    logic          busy;           // req seen, ack still pending

    ////////////////////
    // four-phase responder
    ////////////////////

    // falling edge, so the core samples settled values
    always @(negedge clk) begin
        if (rst) begin
            memRsp <= '0;
            delay  <= 0;
            busy   <= 1'b0;
        end else if (memRsp.ack) begin
            if (!memReq.req) begin
                memRsp.ack <= 1'b0;     // req gone, close the cycle
            end
        end else if (busy) begin
            if (delay == 0) begin
                memRsp.ack  <= 1'b1;
                memRsp.data <= mem[memReq.addr[5:0]];
                busy        <= 1'b0;
            end else begin
                delay <= delay - 1;
            end
        end else if (memReq.req) begin
            delay <= {$random(seed)} % 4;    // 0 to 3 wait cycles
            busy  <= 1'b1;
        end
    end

endmodule

//--- test/tbSapCore.sv
`timescale 1ns/1ps

module tbSapCore;

    localparam logic [2:0] kindAlu    = 3'd0;
    localparam logic [2:0] kindBranch = 3'd1;
    localparam logic [2:0] kindMove   = 3'd2;
    localparam logic [2:0] kindJump   = 3'd3;
    localparam logic [2:0] kindDrop   = 3'd4;    // mul opcode or source 15
    localparam int         timeoutCycles = 1000;

    typedef struct packed {
        logic [2:0]    kind;
        logic [3:0]    op;
        sapPkg::word_t a;
        sapPkg::word_t b;
        sapPkg::word_t expected;    // outPort at the first strobe
    } row_t;

    logic            clk = 1'b1;
    logic            rst;
    sapPkg::word_t   inPort;
    sapPkg::word_t   outPort;
    logic            outStrobe;
    sapPkg::memReq_t memReq;
    sapPkg::memRsp_t memRsp;
    row_t            rows [$];
    logic [5:0]      progPtr;
    integer          seed = 8015;

    always #2 clk = ~clk;

    sapCore #(
        .resetAddr(16'h0000)
    ) i_sapCore (
        .clk(clk), .rst(rst),
        .inPort(inPort), .outPort(outPort), .outStrobe(outStrobe),
        .memReq(memReq), .memRsp(memRsp)
    );

    progMemModel i_progMemModel (
        .clk(clk), .rst(rst), .memReq(memReq), .memRsp(memRsp)
    );

    ////////////////////
    // reference model
    ////////////////////

    function automatic sapPkg::word_t aluModel(input logic [3:0] op,
                                               input sapPkg::word_t a, input sapPkg::word_t b);
        case (op)
            4'd0:    return a & b;
            4'd1:    return a | b;
            4'd10:   return ~a;
            4'd11:   return a ^ b;
            4'd12:   return a + b;     // 16-bit wrap
            4'd13:   return a - b;
            default: return 16'h0000;
        endcase
    endfunction

    // taken path writes 2 and fall-through writes 1
    function automatic sapPkg::word_t branchModel(input logic [3:0] cond,
                                                  input sapPkg::word_t a, input sapPkg::word_t b);
        logic taken;
        case (cond)
            4'd4:    taken = (a == b);
            4'd5:    taken = (a != b);
            4'd6:    taken = (a > b);
            4'd7:    taken = (a >= b);
            4'd8:    taken = (a < b);
            4'd9:    taken = (a <= b);
            default: taken = 1'b0;
        endcase
        return taken ? 16'd2 : 16'd1;
    endfunction

    function automatic sapPkg::word_t ldImm(input logic [3:0] dst);
        return {4'h1, dst, 8'h02};
    endfunction

    function automatic sapPkg::word_t mov(input logic [3:0] src, input logic [3:0] dst);
        return {src, dst, 8'h00};
    endfunction

    ////////////////////
    // helpers
    ////////////////////

    task automatic abortRun();
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkValue(input sapPkg::word_t actual, input sapPkg::word_t expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            abortRun();
        end
    endtask

    task automatic addRow(input logic [2:0] kind, input logic [3:0] op,
                          input sapPkg::word_t a, input sapPkg::word_t b,
                          input sapPkg::word_t expected);
        row_t r;
        r.kind     = kind;
        r.op       = op;
        r.a        = a;
        r.b        = b;
        r.expected = expected;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        logic [3:0]    aluOps [6];
        sapPkg::word_t pairA [3];
        sapPkg::word_t pairB [3];
        sapPkg::word_t ra;
        sapPkg::word_t rb;
        int            k;
        aluOps = '{4'd0, 4'd1, 4'd10, 4'd11, 4'd12, 4'd13};
        pairA  = '{16'h1234, 16'h0005, 16'h9000};    // equal, less, greater
        pairB  = '{16'h1234, 16'h8000, 16'h0007};
        for (int i = 0; i < 6; i++) begin
            addRow(kindAlu, aluOps[i], 16'hFFF0, 16'h0025,
                   aluModel(aluOps[i], 16'hFFF0, 16'h0025));
            addRow(kindAlu, aluOps[i], 16'h0003, 16'h0F00,
                   aluModel(aluOps[i], 16'h0003, 16'h0F00));
        end
        for (int i = 0; i < 4; i++) begin
            k  = {$random(seed)} % 6;
            ra = sapPkg::word_t'($random(seed));
            rb = sapPkg::word_t'($random(seed));
            addRow(kindAlu, aluOps[k], ra, rb, aluModel(aluOps[k], ra, rb));
        end
        addRow(kindMove, 4'd0, 16'hBEEF, 16'h0000, 16'hBEEF);
        addRow(kindMove, 4'd0, 16'h8001, 16'h0000, 16'h8001);
        addRow(kindJump, 4'd0, 16'h0001, 16'h0002, 16'h0002);
        for (int c = 4; c <= 9; c++) begin
            for (int p = 0; p < 3; p++) begin
                addRow(kindBranch, c[3:0], pairA[p], pairB[p],
                       branchModel(c[3:0], pairA[p], pairB[p]));
            end
        end
        addRow(kindDrop, 4'd14, 16'h1357, 16'h0002, 16'h1357);   // r0 untouched
        addRow(kindDrop, 4'd15, 16'h2468, 16'h0002, 16'h0000);   // source reads zero
    endtask

    task automatic emit(input sapPkg::word_t w);
        i_progMemModel.mem[progPtr] = w;
        progPtr = progPtr + 6'd1;
    endtask

    task automatic loadProgram(input row_t r);
        for (int i = 0; i < 64; i++) begin
            i_progMemModel.mem[i[5:0]] = 16'h0000;   // nop
        end
        progPtr = 6'd0;
        case (r.kind)
            kindAlu: begin
                emit(ldImm(4'd7));                   // acc
                emit(r.a);
                emit(ldImm(4'd8));                   // bReg
                emit(r.b);
                emit({4'd3, 4'd11, 4'd12, r.op});    // r0 = acc op bReg
                emit(mov(4'd7, 4'd10));
            end
            kindMove: emit(mov(4'd4, 4'd10));        // inPort to outPort
            kindJump: begin
                emit(16'h0001);
                emit(16'd4);
                emit(ldImm(4'd10));                  // skipped
                emit(r.a);
                emit(ldImm(4'd10));
                emit(r.b);
            end
            kindBranch: begin
                emit(ldImm(4'd7));
                emit(r.a);
                emit(ldImm(4'd8));
                emit(r.b);
                emit(ldImm(4'd9));                   // target in c
                emit(16'd10);
                emit({4'd11, 4'd12, 4'd13, r.op});
                emit(ldImm(4'd10));                  // fall-through
                emit(16'd1);
                emit(16'h0000);
                emit(ldImm(4'd10));                  // address 10
                emit(16'd2);
            end
            default: begin
                emit(ldImm(4'd3));                   // r0 preset
                emit(r.a);
                emit(ldImm(4'd7));
                emit(r.a);
                emit(ldImm(4'd8));
                emit(r.b);
                emit((r.op == 4'd14) ? {4'd3, 4'd11, 4'd12, 4'd14} : mov(4'd15, 4'd3));
                emit(mov(4'd7, 4'd10));
            end
        endcase
    endtask

    task automatic resetWithProgram(input row_t r);
        @(negedge clk);
        rst    = 1'b1;
        inPort = (r.kind == kindMove) ? r.a : 16'hA5A5;
        loadProgram(r);
        repeat (2) begin
            @(negedge clk);
            checkValue({15'd0, memReq.req}, 16'h0000, "req in reset");
            checkValue({15'd0, outStrobe}, 16'h0000, "outStrobe in reset");
        end
        checkValue(outPort, 16'h0000, "outPort after reset");
        rst = 1'b0;
    endtask

    task automatic runRow(input int idx, input row_t r);
        int cycles;
        resetWithProgram(r);
        cycles = 0;
        while (outStrobe !== 1'b1 && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
        end
        if (outStrobe !== 1'b1) begin
            $display("row %0d timed out waiting for outStrobe", idx);
            abortRun();
        end
        checkValue(outPort, r.expected, $sformatf("row %0d outPort", idx));
        @(negedge clk);
        checkValue({15'd0, outStrobe}, 16'h0000,
                   $sformatf("row %0d outStrobe one cycle later", idx));
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        rst    = 1'b1;
        inPort = 16'h0000;
        buildTable();
        for (int i = 0; i < rows.size(); i++) begin
            runRow(i, rows[i]);
        end
        $display("Test passed");
        $finish;
    end

endmodule

//--- verilog.f
hw/sapPkg.sv
hw/aluUnit.sv
hw/fetchUnit.sv
hw/regFile.sv
hw/seqControl.sv
hw/sapCore.sv
test/progMemModel.sv
test/tbSapCore.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --assert --timing
TOP       = tbSapCore
FILELIST  = verilog.f
OBJDIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(OBJDIR)
